/* Bender.yml */
package:
  name: pulse_filter

sources:
  # filter RTL, package first
  - files:
      - src/pulse_filter_pkg.sv
      - src/line_ram.sv
      - src/line_buffer_wr.sv
      - src/line_buffer_rd.sv
      - src/pulse_filter_core.sv
      - src/pulse_filter_top.sv

  # testbench, bound checker and frame model header
  - target: test
    include_dirs:
      - include
    files:
      - sim/pulse_filter_chk.sv
      - sim/tb_pulse_filter.sv

/* compile.f */
+incdir+include
src/pulse_filter_pkg.sv
src/line_ram.sv
src/line_buffer_wr.sv
src/line_buffer_rd.sv
src/pulse_filter_core.sv
src/pulse_filter_top.sv
sim/pulse_filter_chk.sv
sim/tb_pulse_filter.sv

/* sim/pulse_filter_chk.sv */
// protocol assertions on the filter top level
// bound to pulse_filter_top, failures are counted for the testbench summary
`timescale 1ns/1ns

module pulse_filter_chk (
	input logic clk,
	input logic i_reset,
	input logic [pulse_filter_pkg::NUM_LINE_BUFS-1:0] i_wr_en,
	input pulse_filter_pkg::pix_beat_t i_out_beat
);
	import pulse_filter_pkg::*;

	int assert_failures = 0;

	// each line goes to a single RAM
	wr_en_onehot: assert property (@(posedge clk) disable iff (i_reset)
		$onehot0(i_wr_en))
		else begin
			assert_failures++;
			$error("more than one line RAM write enable high");
		end

	// no output line outside a frame
	lval_in_frame: assert property (@(posedge clk) disable iff (i_reset)
		i_out_beat.lval |-> i_out_beat.fval)
		else begin
			assert_failures++;
			$error("output lval high while output fval low");
		end

	// pipeline is empty right after reset
	quiet_after_reset: assert property (@(posedge clk)
		$fell(i_reset) |-> !i_out_beat.lval [*PIPE_LATENCY])
		else begin
			assert_failures++;
			$error("output lval high within the pipeline latency after reset");
		end

endmodule

bind pulse_filter_top pulse_filter_chk pulse_filter_chk_inst (
	.clk(clk),
	.i_reset(i_reset),
	.i_wr_en(wr_en),
	.i_out_beat(o_beat)
);

/* include/tb_frame_model.svh */
// reference model of the impulse filter for the testbench
// include inside the testbench module, fill a frame, then build its expected rows
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// size of the frame in the store
int frame_width;
int frame_height;
// frame store, row major
pulse_filter_pkg::pix_t frame [][];
// expected output pixels, oldest first, across frames
pulse_filter_pkg::pix_t expected [$];

// size the store for a new frame
function automatic void new_frame(int w, int h);
	frame_width = w;
	frame_height = h;
	frame = new[h];
	foreach (frame[r]) begin
		frame[r] = new[w];
	end
endfunction

function automatic void set_pix(int row, int col, pulse_filter_pkg::pix_t value);
	frame[row][col] = value;
endfunction

// clamp rule on one interior pixel
function automatic pulse_filter_pkg::pix_t clamp(int row, int col,
	pulse_filter_pkg::pix_t thr);
	int centre;
	int nb_max;
	int nb_min;
	centre = frame[row][col];
	nb_max = 0;
	nb_min = (1 << pulse_filter_pkg::PIX_WIDTH) - 1;
	for (int r = row - 1; r <= row + 1; r++) begin
		for (int c = col - 1; c <= col + 1; c++) begin
			if (r != row || c != col) begin
				if (frame[r][c] > nb_max) begin
					nb_max = frame[r][c];
				end
				if (frame[r][c] < nb_min) begin
					nb_min = frame[r][c];
				end
			end
		end
	end
	// hot spike then cold spike
	if (centre > nb_max + int'(thr)) begin
		return pulse_filter_pkg::pix_t'(nb_max);
	end
	if (nb_min > centre + int'(thr)) begin
		return pulse_filter_pkg::pix_t'(nb_min);
	end
	return frame[row][col];
endfunction

// rows 1 to H-2, edge columns as stored
function automatic void build_expected(pulse_filter_pkg::pix_t thr, bit filter_en);
	for (int r = 1; r <= frame_height - 2; r++) begin
		for (int c = 0; c < frame_width; c++) begin
			if (!filter_en || c == 0 || c == frame_width - 1) begin
				expected.push_back(frame[r][c]);
			end else begin
				expected.push_back(clamp(r, c, thr));
			end
		end
	end
endfunction

`endif

/* sim/tb_pulse_filter.sv */
// testbench for the impulse noise filter top level
// drives random frames with hot and cold spikes, checks every output beat
// against the frame model, and counts output lines and pixels per frame
`timescale 1ns/1ns

module tb_pulse_filter;
	import pulse_filter_pkg::*;

	`include "tb_frame_model.svh"

	// --------------------
	// run constants
	// --------------------
	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 2;
	localparam int RESET_CYCLES = 10;
	localparam logic [31:0] SEED = 32'h2f069f8d;
	localparam int MAX_W = 64;
	localparam int MAX_H = 12;
	localparam int MAX_LINE_GAP = 4;
	localparam int MAX_FRAME_GAP = 8;
	localparam int NUM_TESTS = 5;
	localparam int NUM_FRAMES = 18;
	localparam int DRAIN_MARGIN = 50;
	// lead beat, all lines with their widest gaps, widest frame gap
	localparam int MAX_FRAME_CYCLES = 1 + MAX_H * (MAX_W + MAX_LINE_GAP) + MAX_FRAME_GAP;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_FRAMES * MAX_FRAME_CYCLES +
		NUM_TESTS * (PIPE_LATENCY + DRAIN_MARGIN);

	logic clk;
	logic i_reset;
	pix_beat_t i_beat;
	pix_t i_threshold;
	logic i_filter_en;
	pix_beat_t o_beat;

	// expected output qualifiers, keyed by the cycle the input was driven
	pix_beat_t exp_flags [int];
	pix_beat_t exp_now;
	pix_beat_t prev_beat;
	// sizes of frames still in flight, oldest first
	int frame_w [$];
	int frame_h [$];
	int cyc;
	int errors;
	int tests_run;
	int tests_failed;
	int line_pix;
	int out_lines;

	pulse_filter_top pulse_filter_top_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_beat(i_beat),
		.i_threshold(i_threshold),
		.i_filter_en(i_filter_en),
		.o_beat(o_beat)
	);

	// --------------------
	// clock and cycle count
	// --------------------
	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	initial cyc = 0;
	always @(posedge clk) cyc++;

	// --------------------
	// compare tasks
	// --------------------
	task automatic compare_pix(pix_t got, pix_t exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t o_beat.data exp=%0d got=%0d", $time, exp, got);
		end
	endtask

	task automatic compare_beat_flags(pix_beat_t got, pix_beat_t exp);
		if (got.fval !== exp.fval) begin
			errors++;
			$display("MISMATCH t=%0t o_beat.fval exp=%b got=%b", $time, exp.fval, got.fval);
		end
		if (got.lval !== exp.lval) begin
			errors++;
			$display("MISMATCH t=%0t o_beat.lval exp=%b got=%b", $time, exp.lval, got.lval);
		end
	endtask

	task automatic compare_count(string name, int got, int exp);
		if (got != exp) begin
			errors++;
			$display("MISMATCH t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
		end
	endtask

	// --------------------
	// stimulus
	// --------------------
	function automatic pix_t rand_pix();
		return pix_t'($urandom);
	endfunction

	// one beat per cycle, out_lval is what the output should show 4 cycles on
	task automatic drive_beat(logic fval, logic lval, logic out_lval, pix_t data);
		@(posedge clk);
		#DRIVE_DLY;
		i_beat = '{fval: fval, lval: lval, data: data};
		exp_flags[cyc] = '{fval: fval, lval: out_lval, data: '0};
	endtask

	// smooth level around a random base, spikes of 150 to 200 either way
	task automatic fill_frame(int w, int h, int noise, int spike_pct);
		int base;
		int v;
		new_frame(w, h);
		base = $urandom_range(200, 800);
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				v = base + int'($urandom_range(0, 2 * noise)) - noise;
				if ($urandom_range(0, 99) < spike_pct) begin
					if ($urandom_range(0, 1) == 1) begin
						v = v + 150 + int'($urandom_range(0, 50));
					end else begin
						v = v - 150 - int'($urandom_range(0, 50));
					end
				end
				set_pix(r, c, pix_t'(v));
			end
		end
	endtask

	// first two lines fill the RAMs and give no output
	task automatic drive_frame(int w, int h, int fgap);
		int gap;
		drive_beat(1'b1, 1'b0, 1'b0, rand_pix());
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				drive_beat(1'b1, 1'b1, r >= 2, frame[r][c]);
			end
			gap = $urandom_range(1, MAX_LINE_GAP);
			repeat (gap) drive_beat(1'b1, 1'b0, 1'b0, rand_pix());
		end
		repeat (fgap) drive_beat(1'b0, 1'b0, 1'b0, rand_pix());
	endtask

	task automatic run_test(string name, int n_frames, int min_h, int thr, bit en,
		int noise, int spike_pct, int min_fgap, int max_fgap);
		int start_errors;
		int w;
		int h;
		start_errors = errors;
		// settings change only while the pipeline is idle
		@(posedge clk);
		#DRIVE_DLY;
		i_threshold = pix_t'(thr);
		i_filter_en = en;
		for (int f = 0; f < n_frames; f++) begin
			w = $urandom_range(8, MAX_W);
			h = $urandom_range(min_h, MAX_H);
			fill_frame(w, h, noise, spike_pct);
			build_expected(pix_t'(thr), en);
			frame_w.push_back(w);
			frame_h.push_back(h);
			drive_frame(w, h, $urandom_range(min_fgap, max_fgap));
		end
		// idle until every frame has come out, the watchdog bounds this
		while (expected.size() != 0 || frame_h.size() != 0) begin
			drive_beat(1'b0, 1'b0, 1'b0, rand_pix());
		end
		repeat (PIPE_LATENCY) drive_beat(1'b0, 1'b0, 1'b0, rand_pix());
		tests_run++;
		if (errors == start_errors) begin
			$display("test %s: ok, %0d frames", name, n_frames);
		end else begin
			tests_failed++;
			$display("test %s: failed, %0d errors", name, errors - start_errors);
		end
	endtask

	// --------------------
	// output monitor
	// --------------------
	// samples at the falling edge, half a cycle after the output register
	always @(negedge clk) begin
		if (!i_reset) begin
			exp_now = '0;
			if (exp_flags.exists(cyc - PIPE_LATENCY)) begin
				exp_now = exp_flags[cyc - PIPE_LATENCY];
				exp_flags.delete(cyc - PIPE_LATENCY);
			end
			compare_beat_flags(o_beat, exp_now);
			if (o_beat.lval) begin
				line_pix++;
				if (expected.size() == 0) begin
					errors++;
					$display("ERROR t=%0t output pixel with no expected pixel left", $time);
				end else begin
					compare_pix(o_beat.data, expected.pop_front());
				end
			end
			// end of an output line
			if (prev_beat.lval && !o_beat.lval) begin
				if (frame_w.size() != 0) begin
					compare_count("pixels per output line", line_pix, frame_w[0]);
				end
				line_pix = 0;
				out_lines++;
			end
			// end of an output frame
			if (prev_beat.fval && !o_beat.fval) begin
				if (frame_h.size() == 0) begin
					errors++;
					$display("ERROR t=%0t output frame ended with no frame sent", $time);
				end else begin
					compare_count("output lines per frame", out_lines, frame_h.pop_front() - 2);
					void'(frame_w.pop_front());
				end
				out_lines = 0;
			end
			prev_beat = o_beat;
		end
	end

	// --------------------
	// watchdog
	// --------------------
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("ERROR: watchdog expired after %0d cycles, output did not drain",
			WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// --------------------
	// test sequence
	// --------------------
	initial begin
		void'($urandom(SEED));
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		line_pix = 0;
		out_lines = 0;
		prev_beat = '0;
		i_reset = 1'b1;
		i_beat = '0;
		i_threshold = '0;
		i_filter_en = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		i_reset = 1'b0;

		// name, frames, min height, threshold, enable, noise, spike %, frame gap
		run_test("spike_removal", 3, 4, 40, 1'b1, 8, 8, 2, MAX_FRAME_GAP);
		run_test("pass_below_threshold", 3, 4, 255, 1'b1, 30, 0, 2, MAX_FRAME_GAP);
		run_test("bypass", 3, 4, 20, 1'b0, 8, 10, 2, MAX_FRAME_GAP);
		run_test("row_and_latency", 4, 4, $urandom_range(10, 60), 1'b1, 12, 5, 2,
			MAX_FRAME_GAP);
		// shortest fval gap, frames taller than the RAM ring
		run_test("back_to_back", 5, 5, 30, 1'b1, 8, 8, 1, 1);

		if (pulse_filter_top_inst.pulse_filter_chk_inst.assert_failures != 0) begin
			errors += pulse_filter_top_inst.pulse_filter_chk_inst.assert_failures;
			$display("ERROR: %0d protocol assertion failures",
				pulse_filter_top_inst.pulse_filter_chk_inst.assert_failures);
		end
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* src/line_buffer_rd.sv */
// read stage of the line buffers
// fetches the two stored lines at the current column and
// returns them as one column together with the current pixel
`timescale 1ns/1ns

module line_buffer_rd (
	input logic clk,
	input logic i_reset,
	input pulse_filter_pkg::line_wr_t i_line,
	input pulse_filter_pkg::pix_t [pulse_filter_pkg::NUM_LINE_BUFS-1:0] i_rd_data,
	output pulse_filter_pkg::line_addr_t o_rd_addr,
	output pulse_filter_pkg::column_t o_column
);
	import pulse_filter_pkg::*;

	logic fval_d;
	logic lval_d;
	logic rows_ready_d;
	buf_sel_t buf_sel_d;
	pix_t lower_d;
	buf_sel_t mid_sel;
	buf_sel_t up_sel;

	// same column of every RAM, the one being written is ignored
	assign o_rd_addr = i_line.addr;

	// --------------------
	// match RAM read latency
	// --------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			fval_d <= 1'b0;
			lval_d <= 1'b0;
			rows_ready_d <= 1'b0;
			buf_sel_d <= '0;
		end else begin
			fval_d <= i_line.fval;
			lval_d <= i_line.lval;
			rows_ready_d <= i_line.rows_ready;
			buf_sel_d <= i_line.buf_sel;
		end
	end

	// current line pixel, becomes the lower row
	always_ff @(posedge clk) begin
		lower_d <= i_line.data;
	end

	// previous line one RAM back, the one before two back
	// wraps modulo four through the index width
	always_comb begin
		mid_sel = buf_sel_d - 1'b1;
		up_sel = buf_sel_d - 2'd2;
	end

	// --------------------
	// column word
	// --------------------
	assign o_column = '{
		upper: i_rd_data[up_sel],
		middle: i_rd_data[mid_sel],
		lower: lower_d,
		fval: fval_d,
		lval: lval_d,
		rows_ready: rows_ready_d
	};

endmodule

/* src/line_buffer_wr.sv */
// write stage of the line buffers
// stores each input line in the next of the four line RAMs and
// hands the registered beat with its column and RAM index to the read stage
`timescale 1ns/1ns

module line_buffer_wr (
	input logic clk,
	input logic i_reset,
	input pulse_filter_pkg::pix_beat_t i_beat,
	output logic [pulse_filter_pkg::NUM_LINE_BUFS-1:0] o_wr_en,
	output pulse_filter_pkg::line_addr_t o_wr_addr,
	output pulse_filter_pkg::pix_t o_wr_data,
	output pulse_filter_pkg::line_wr_t o_line
);
	import pulse_filter_pkg::*;

	logic fval_q;
	logic lval_q;
	logic lval_fall;
	line_addr_t addr_q;
	buf_sel_t buf_sel_q;
	logic rows_ready_q;
	pix_t data_q;

	// --------------------
	// qualifier delay
	// --------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			fval_q <= 1'b0;
			lval_q <= 1'b0;
		end else begin
			fval_q <= i_beat.fval;
			lval_q <= i_beat.lval;
		end
	end

	// end of a line, last pixel is in the register now
	assign lval_fall = lval_q && !i_beat.lval;

	// --------------------
	// line counter
	// --------------------
	// fval gap restarts at RAM 0
	// rows_ready sets when line 1 ends and holds to frame end
	always_ff @(posedge clk) begin
		if (i_reset || !i_beat.fval) begin
			buf_sel_q <= '0;
			rows_ready_q <= 1'b0;
		end else if (lval_fall) begin
			buf_sel_q <= buf_sel_q + 1'b1;
			if (buf_sel_q == buf_sel_t'(1)) begin
				rows_ready_q <= 1'b1;
			end
		end
	end

	// column index of the registered pixel, zero between lines
	always_ff @(posedge clk) begin
		if (i_reset || !i_beat.lval) begin
			addr_q <= '0;
		end else if (lval_q) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	// pixel lines up with enable and address
	always_ff @(posedge clk) begin
		data_q <= i_beat.data;
	end

	// one-hot enable of the RAM that owns this line
	always_comb begin
		o_wr_en = '0;
		if (fval_q && lval_q) begin
			o_wr_en[buf_sel_q] = 1'b1;
		end
	end

	assign o_wr_addr = addr_q;
	assign o_wr_data = data_q;

	assign o_line = '{
		fval: fval_q,
		lval: lval_q,
		addr: addr_q,
		buf_sel: buf_sel_q,
		rows_ready: rows_ready_q,
		data: data_q
	};

endmodule

/* src/line_ram.sv */
// one line of pixel storage for the filter window
// write port from the write stage, registered read port for the read stage
`timescale 1ns/1ns

module line_ram (
	input logic clk,
	input logic i_wr_en,
	input pulse_filter_pkg::line_addr_t i_wr_addr,
	input pulse_filter_pkg::pix_t i_wr_data,
	input pulse_filter_pkg::line_addr_t i_rd_addr,
	output pulse_filter_pkg::pix_t o_rd_data
);
	import pulse_filter_pkg::*;

	// full address range, one pixel per word
	pix_t mem [2**LINE_ADDR_WIDTH];

	// write side
	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// read side, data one cycle after the address
	always_ff @(posedge clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

/* src/pulse_filter_core.sv */
// 3x3 window and impulse clamp
// a centre pixel beyond all eight neighbours by more than the threshold
// is replaced by the nearest neighbour extreme, line edges pass unchanged
`timescale 1ns/1ns

module pulse_filter_core (
	input logic clk,
	input logic i_reset,
	input pulse_filter_pkg::column_t i_column,
	input pulse_filter_pkg::pix_t i_threshold,
	input logic i_filter_en,
	output pulse_filter_pkg::pix_beat_t o_beat
);
	import pulse_filter_pkg::*;

	// columns packed as {upper, middle, lower}
	pix_t [2:0] col_r;
	pix_t [2:0] col_c;
	pix_t [2:0] col_l;
	logic lval_l;
	logic lval_c;
	logic fval_c;
	logic rows_ready_c;

	// eight neighbours of the centre
	pix_t [7:0] nb;
	pix_t nb_max;
	pix_t nb_min;
	pix_t centre;
	pix_t result;
	logic at_edge;
	logic [PIX_WIDTH:0] hot_limit;
	logic [PIX_WIDTH:0] cold_limit;

	logic out_fval;
	logic out_lval;
	pix_t out_data;

	// --------------------
	// window shift
	// --------------------
	// right column is the incoming one
	assign col_r = {i_column.upper, i_column.middle, i_column.lower};

	always_ff @(posedge clk) begin
		col_c <= col_r;
		col_l <= col_c;
	end

	// qualifiers of centre and left column
	always_ff @(posedge clk) begin
		if (i_reset) begin
			lval_c <= 1'b0;
			lval_l <= 1'b0;
			fval_c <= 1'b0;
			rows_ready_c <= 1'b0;
		end else begin
			lval_c <= i_column.lval;
			lval_l <= lval_c;
			fval_c <= i_column.fval;
			rows_ready_c <= i_column.rows_ready;
		end
	end

	// full left and right columns, upper and lower of the centre
	assign nb = {col_l, col_r, col_c[2], col_c[0]};

	// --------------------
	// neighbour extremes
	// --------------------
	always_comb begin
		nb_max = nb[0];
		nb_min = nb[0];
		for (int i = 1; i < $size(nb); i++) begin
			if (nb[i] > nb_max) begin
				nb_max = nb[i];
			end
			if (nb[i] < nb_min) begin
				nb_min = nb[i];
			end
		end
	end

	// clamp decision
	always_comb begin
		centre = col_c[1];
		// neighbour outside the line on either side
		at_edge = !lval_l || !i_column.lval;
		// one extra bit so the sums never wrap
		hot_limit = {1'b0, nb_max} + {1'b0, i_threshold};
		cold_limit = {1'b0, centre} + {1'b0, i_threshold};
		result = centre;
		if (i_filter_en && !at_edge) begin
			if ({1'b0, centre} > hot_limit) begin
				result = nb_max;
			end else if ({1'b0, nb_min} > cold_limit) begin
				result = nb_min;
			end
		end
	end

	// --------------------
	// output register
	// --------------------
	// no output line until upper row exists
	always_ff @(posedge clk) begin
		if (i_reset) begin
			out_fval <= 1'b0;
			out_lval <= 1'b0;
		end else begin
			out_fval <= fval_c;
			out_lval <= lval_c && rows_ready_c;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= result;
	end

	assign o_beat = '{fval: out_fval, lval: out_lval, data: out_data};

endmodule

/* src/pulse_filter_pkg.sv */
// shared sizes and stage word types of the impulse noise filter
// every filter module imports this package in its body

package pulse_filter_pkg;

	// --------------------
	// sizes
	// --------------------
	// sensor pixel width
	localparam int PIX_WIDTH = 10;
	// lines up to 4096 pixels
	localparam int LINE_ADDR_WIDTH = 12;
	// rotating line stores
	localparam int NUM_LINE_BUFS = 4;
	localparam int BUF_SEL_WIDTH = $clog2(NUM_LINE_BUFS);
	// input pixel to filtered pixel of the line above, same column
	localparam int PIPE_LATENCY = 4;

	// --------------------
	// types
	// --------------------
	typedef logic [PIX_WIDTH-1:0] pix_t;
	typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
	typedef logic [BUF_SEL_WIDTH-1:0] buf_sel_t;

	// one sensor beat, used at both input and output
	typedef struct packed {
		logic fval;
		logic lval;
		pix_t data;
	} pix_beat_t;

	// write stage result, one cycle after the input beat
	typedef struct packed {
		logic fval;
		logic lval;
		line_addr_t addr;
		buf_sel_t buf_sel;
		// two full lines of this frame stored
		logic rows_ready;
		pix_t data;
	} line_wr_t;

	// one aligned column, lower is the current input line
	typedef struct packed {
		pix_t upper;
		pix_t middle;
		pix_t lower;
		logic fval;
		logic lval;
		logic rows_ready;
	} column_t;

endpackage

/* src/pulse_filter_top.sv */
// impulse noise filter top level
// write stage, four line RAMs, read stage and filter core in a fixed pipeline
`timescale 1ns/1ns

module pulse_filter_top (
	input logic clk,
	input logic i_reset,
	input pulse_filter_pkg::pix_beat_t i_beat,
	input pulse_filter_pkg::pix_t i_threshold,
	input logic i_filter_en,
	output pulse_filter_pkg::pix_beat_t o_beat
);
	import pulse_filter_pkg::*;

	logic [NUM_LINE_BUFS-1:0] wr_en;
	line_addr_t wr_addr;
	pix_t wr_data;
	line_addr_t rd_addr;
	pix_t [NUM_LINE_BUFS-1:0] rd_data;
	line_wr_t wr_line;
	column_t column;

	// --------------------
	// write stage
	// --------------------
	line_buffer_wr line_buffer_wr_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_beat(i_beat),
		.o_wr_en(wr_en),
		.o_wr_addr(wr_addr),
		.o_wr_data(wr_data),
		.o_line(wr_line)
	);

	// line stores, shared address and data
	for (genvar i = 0; i < NUM_LINE_BUFS; i++) begin : g_ram
		line_ram line_ram_inst (
			.clk(clk),
			.i_wr_en(wr_en[i]),
			.i_wr_addr(wr_addr),
			.i_wr_data(wr_data),
			.i_rd_addr(rd_addr),
			.o_rd_data(rd_data[i])
		);
	end

	// --------------------
	// read stage and core
	// --------------------
	line_buffer_rd line_buffer_rd_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_line(wr_line),
		.i_rd_data(rd_data),
		.o_rd_addr(rd_addr),
		.o_column(column)
	);

	pulse_filter_core pulse_filter_core_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_column(column),
		.i_threshold(i_threshold),
		.i_filter_en(i_filter_en),
		.o_beat(o_beat)
	);

endmodule
